// ==== hw/dmrs_correlator.sv ====
`timescale 1ns/1ps

module dmrs_correlator (
    input  logic                  clk_i,
    input  logic                  reset_ni,
    pilot_if.sink                 pilot,
    dmrs_rd_if.execute            dmrs,
    output pbch_pkg::corr_array_t corr_o,
    output logic                  corr_done_o
);
    import pbch_pkg::*;

    corr_array_t acc_q;
    corr_array_t acc_next;

    // the table row for the current pilot comes back in the same cycle
    assign dmrs.rd_idx = pilot.idx;

    // each pilot adds 0, 1 or 2 matching bits per candidate
    always_comb begin
        for (int i = 0; i < NUM_IBAR; i++) begin
            acc_next[i] = acc_q[i];
            if (pilot.valid) begin
                acc_next[i] = acc_q[i]
                              + CORR_W'(dmrs.rd_row[i][1] ~^ pilot.bits[1])
                              + CORR_W'(dmrs.rd_row[i][0] ~^ pilot.bits[0]);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            acc_q <= '0;
            corr_o <= '0;
            corr_done_o <= 1'b0;
        end else begin
            corr_done_o <= pilot.last;
            if (pilot.last) begin
                // clear here so the next symbol can follow right away
                corr_o <= acc_next;
                acc_q <= '0;
            end else begin
                acc_q <= acc_next;
            end
        end
    end

endmodule

// ==== hw/ibar_select.sv ====
`timescale 1ns/1ps

module ibar_select (
    input  logic                        clk_i,
    input  logic                        reset_ni,
    input  pbch_pkg::corr_array_t       corr_i,
    input  logic                        corr_done_i,
    output logic [pbch_pkg::IBAR_W-1:0] ibar_o,
    output logic [pbch_pkg::CORR_W-1:0] ibar_corr_o,
    output logic                        ibar_valid_o
);
    import pbch_pkg::*;

    logic [IBAR_W-1:0] best_idx;
    logic [CORR_W-1:0] best_cnt;

    // strict compare keeps the lowest index on a tie
    always_comb begin
        best_idx = '0;
        best_cnt = '0;
        for (int i = 0; i < NUM_IBAR; i++) begin
            if (corr_i[i] > best_cnt) begin
                best_cnt = corr_i[i];
                best_idx = IBAR_W'(i);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            ibar_o <= '0;
            ibar_corr_o <= '0;
            ibar_valid_o <= 1'b0;
        end else begin
            ibar_valid_o <= corr_done_i;
            if (corr_done_i) begin
                ibar_o <= best_idx;
                ibar_corr_o <= best_cnt;
            end
        end
    end

endmodule

// ==== hw/pbch_dmrs_gen.sv ====
`timescale 1ns/1ps

module pbch_dmrs_gen (
    input  logic                       clk_i,
    input  logic                       reset_ni,
    input  logic [pbch_pkg::NID_W-1:0] n_id_i,
    input  logic                       n_id_valid_i,
    dmrs_rd_if.gen                     rd
);
    import pbch_pkg::*;

    gen_state_e state_q;
    logic [GEN_CNT_W-1:0] cnt_q;
    logic [NID_W-1:0] nid_q;
    logic ready_q;

    logic lfsr_load;
    logic lfsr_step;
    logic x1_bit;
    logic [NUM_IBAR-1:0] x2_bit;
    logic [NUM_IBAR-1:0] gold;
    logic [LFSR_N-1:0] seed [NUM_IBAR];

    // pilot pairs of all candidates, one row per pilot index
    pilot_row_t table_q [PILOTS_PER_SYM];

    // c_init = 2^11 (i+1)(floor(n_id/4)+1) + 2^6 (i+1) + (n_id mod 4)
    function automatic logic [LFSR_N-1:0] c_init(input logic [NID_W-1:0] n_id,
                                                 input logic [IBAR_W-1:0] ibar);
        logic [LFSR_N-1:0] ibar_p1;
        logic [LFSR_N-1:0] nid_p1;
        ibar_p1 = LFSR_N'(ibar) + LFSR_N'(1);
        nid_p1 = LFSR_N'(n_id >> 2) + LFSR_N'(1);
        return ((ibar_p1 * nid_p1) << CINIT_NID_SHIFT) + (ibar_p1 << CINIT_IBAR_SHIFT)
               + LFSR_N'(n_id[1:0]);
    endfunction

    assign lfsr_load = (state_q == GEN_LOAD);
    assign lfsr_step = (state_q == GEN_SKIP) || (state_q == GEN_FILL);

    pn_lfsr #(
        .FEEDBACK_TAPS(X1_TAPS)
    ) u_x1 (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .load_i(lfsr_load),
        .step_i(lfsr_step),
        .seed_i(X1_SEED),
        .bit_o(x1_bit)
    );

    for (genvar g = 0; g < NUM_IBAR; g++) begin : g_x2
        assign seed[g] = c_init(nid_q, IBAR_W'(g));

        pn_lfsr #(
            .FEEDBACK_TAPS(X2_TAPS)
        ) u_x2 (
            .clk_i(clk_i),
            .reset_ni(reset_ni),
            .load_i(lfsr_load),
            .step_i(lfsr_step),
            .seed_i(seed[g]),
            .bit_o(x2_bit[g])
        );
    end

    assign gold = {NUM_IBAR{x1_bit}} ^ x2_bit;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= GEN_IDLE;
            cnt_q <= '0;
            nid_q <= '0;
            ready_q <= 1'b0;
        end else begin
            case (state_q)
                GEN_IDLE, GEN_DONE: begin
                    if (n_id_valid_i) begin
                        nid_q <= n_id_i;
                        ready_q <= 1'b0;
                        state_q <= GEN_LOAD;
                    end
                end
                GEN_LOAD: begin
                    cnt_q <= '0;
                    state_q <= GEN_SKIP;
                end
                GEN_SKIP: begin
                    if (cnt_q == GEN_CNT_W'(GOLD_SKIP - 1)) begin
                        cnt_q <= '0;
                        state_q <= GEN_FILL;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                GEN_FILL: begin
                    if (cnt_q == GEN_CNT_W'(FILL_BITS - 1)) begin
                        ready_q <= 1'b1;
                        state_q <= GEN_DONE;
                    end
                    cnt_q <= cnt_q + 1'b1;
                end
                default: state_q <= GEN_IDLE;
            endcase
        end
    end

    // even bits go to the real half of a pair, odd bits to the imaginary half
    always_ff @(posedge clk_i) begin
        if (state_q == GEN_FILL) begin
            for (int i = 0; i < NUM_IBAR; i++) begin
                table_q[cnt_q[PILOT_IDX_W:1]][i][!cnt_q[0]] <= gold[i];
            end
        end
    end

    assign rd.ready = ready_q;
    assign rd.pilot_offset = nid_q[1:0];
    assign rd.rd_row = table_q[rd.rd_idx];

endmodule

// ==== hw/pbch_ibar_detector.sv ====
`timescale 1ns/1ps

module pbch_ibar_detector (
    input  logic                          clk_i,
    input  logic                          reset_ni,
    input  logic [pbch_pkg::NID_W-1:0]    n_id_i,
    input  logic                          n_id_valid_i,
    input  logic                          pbch_start_i,
    input  logic [pbch_pkg::SAMPLE_W-1:0] sample_i,
    input  logic                          sample_valid_i,
    output logic                          dmrs_ready_o,
    output logic [pbch_pkg::IBAR_W-1:0]   ibar_o,
    output logic [pbch_pkg::CORR_W-1:0]   ibar_corr_o,
    output logic                          ibar_valid_o
);
    import pbch_pkg::*;

    corr_array_t corr;
    logic corr_done;

    dmrs_rd_if dmrs_rd ();
    pilot_if pilot ();

    // builds the eight candidate pilot sequences for the current cell
    pbch_dmrs_gen u_gen (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .n_id_i(n_id_i),
        .n_id_valid_i(n_id_valid_i),
        .rd(dmrs_rd.gen)
    );

    // decode stage
    pilot_demod u_demod (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .pbch_start_i(pbch_start_i),
        .sample_i(sample_i),
        .sample_valid_i(sample_valid_i),
        .dmrs(dmrs_rd.decode),
        .pilot(pilot.src)
    );

    // execute stage
    dmrs_correlator u_corr (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .pilot(pilot.sink),
        .dmrs(dmrs_rd.execute),
        .corr_o(corr),
        .corr_done_o(corr_done)
    );

    // result stage
    ibar_select u_select (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .corr_i(corr),
        .corr_done_i(corr_done),
        .ibar_o(ibar_o),
        .ibar_corr_o(ibar_corr_o),
        .ibar_valid_o(ibar_valid_o)
    );

    assign dmrs_ready_o = dmrs_rd.ready;

endmodule

// ==== hw/pbch_ifs.sv ====
`timescale 1ns/1ps

// pilot table access between the generator and the detector stages
interface dmrs_rd_if;
    import pbch_pkg::*;

    logic ready;
    logic [1:0] pilot_offset;
    logic [PILOT_IDX_W-1:0] rd_idx;
    pilot_row_t rd_row;

    modport gen (output ready, output pilot_offset, output rd_row, input rd_idx);
    modport decode (input ready, input pilot_offset);
    modport execute (output rd_idx, input rd_row);
endinterface

// demodulated pilot stream, one beat per pilot subcarrier
interface pilot_if;
    import pbch_pkg::*;

    logic valid;
    logic [PILOT_IDX_W-1:0] idx;
    pilot_pair_t bits;
    logic last;

    modport src (output valid, output idx, output bits, output last);
    modport sink (input valid, input idx, input bits, input last);
endinterface

// ==== hw/pbch_pkg.sv ====
package pbch_pkg;

    // cell ID and sample formats
    localparam int NID_W = 10;
    localparam int SAMPLE_W = 32;
    localparam int FFT_LEN = 256;
    localparam int SC_IDX_W = 8;

    // candidate sequences and pilots per PBCH symbol
    localparam int NUM_IBAR = 8;
    localparam int IBAR_W = 3;
    localparam int PILOTS_PER_SYM = 64;
    localparam int PILOT_IDX_W = 6;
    localparam int CORR_W = 8;

    // Gold sequence generator, x1 uses x^31 + x^3 + 1
    localparam int LFSR_N = 31;
    localparam logic [LFSR_N-1:0] X1_TAPS = 31'h0000_0009;
    // x2 uses x^31 + x^3 + x^2 + x + 1
    localparam logic [LFSR_N-1:0] X2_TAPS = 31'h0000_000f;
    localparam logic [LFSR_N-1:0] X1_SEED = 31'd1;
    localparam int GOLD_SKIP = 1600;
    localparam int FILL_BITS = 2 * PILOTS_PER_SYM;
    localparam int GEN_CNT_W = $clog2(GOLD_SKIP);

    // bit positions of the two terms in c_init
    localparam int CINIT_NID_SHIFT = 11;
    localparam int CINIT_IBAR_SHIFT = 6;

    // bit 1 is the real sign, bit 0 the imaginary sign
    typedef logic [1:0] pilot_pair_t;
    typedef pilot_pair_t [NUM_IBAR-1:0] pilot_row_t;
    typedef logic [NUM_IBAR-1:0][CORR_W-1:0] corr_array_t;

    typedef enum logic [2:0] {
        GEN_IDLE,
        GEN_LOAD,
        GEN_SKIP,
        GEN_FILL,
        GEN_DONE
    } gen_state_e;

    typedef enum logic {
        DET_IDLE,
        DET_COLLECT
    } det_state_e;

endpackage

// ==== hw/pilot_demod.sv ====
`timescale 1ns/1ps

module pilot_demod (
    input  logic                          clk_i,
    input  logic                          reset_ni,
    input  logic                          pbch_start_i,
    input  logic [pbch_pkg::SAMPLE_W-1:0] sample_i,
    input  logic                          sample_valid_i,
    dmrs_rd_if.decode                     dmrs,
    pilot_if.src                          pilot
);
    import pbch_pkg::*;

    det_state_e state_q;
    logic [SC_IDX_W-1:0] sc_cnt_q;
    logic accept;

    // input register stage
    logic valid_q;
    logic [SAMPLE_W-1:0] sample_q;
    logic [SC_IDX_W-1:0] sc_q;
    logic is_pilot;

    assign accept = (state_q == DET_COLLECT) && sample_valid_i;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= DET_IDLE;
            sc_cnt_q <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept;
            case (state_q)
                DET_IDLE: begin
                    // a start is dropped while the pilot table is being rebuilt
                    if (pbch_start_i && dmrs.ready) begin
                        sc_cnt_q <= '0;
                        state_q <= DET_COLLECT;
                    end
                end
                DET_COLLECT: begin
                    if (sample_valid_i) begin
                        sc_cnt_q <= sc_cnt_q + 1'b1;
                        if (sc_cnt_q == SC_IDX_W'(FFT_LEN - 1)) begin
                            state_q <= DET_IDLE;
                        end
                    end
                end
                default: state_q <= DET_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            sample_q <= sample_i;
            sc_q <= sc_cnt_q;
        end
    end

    // pilots sit on every fourth subcarrier starting at n_id mod 4
    assign is_pilot = valid_q && (sc_q[1:0] == dmrs.pilot_offset);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            pilot.valid <= 1'b0;
            pilot.last <= 1'b0;
        end else begin
            pilot.valid <= is_pilot;
            pilot.last <= valid_q && (sc_q == SC_IDX_W'(FFT_LEN - 1));
        end
    end

    // sign bit of each half is the hard QPSK decision
    always_ff @(posedge clk_i) begin
        if (is_pilot) begin
            pilot.idx <= sc_q[SC_IDX_W-1:2];
            pilot.bits <= {sample_q[SAMPLE_W/2-1], sample_q[SAMPLE_W-1]};
        end
    end

endmodule

// ==== hw/pn_lfsr.sv ====
`timescale 1ns/1ps

module pn_lfsr #(
    parameter logic [pbch_pkg::LFSR_N-1:0] FEEDBACK_TAPS = pbch_pkg::X1_TAPS
) (
    input  logic                        clk_i,
    input  logic                        reset_ni,
    input  logic                        load_i,
    input  logic                        step_i,
    input  logic [pbch_pkg::LFSR_N-1:0] seed_i,
    output logic                        bit_o
);
    import pbch_pkg::*;

    // bit 0 holds x(n), bit LFSR_N-1 holds x(n+30)
    logic [LFSR_N-1:0] state_q;
    logic feedback;

    // x(n+31) is the parity of the tapped bits
    assign feedback = ^(state_q & FEEDBACK_TAPS);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= '0;
        end else if (load_i) begin
            state_q <= seed_i;
        end else if (step_i) begin
            state_q <= {feedback, state_q[LFSR_N-1:1]};
        end
    end

    // oldest bit first, so sequence bit 0 is visible right after the load
    assign bit_o = state_q[0];

endmodule

// ==== tests/pbch_ibar_asserts.sv ====
`timescale 1ns/1ps

module pbch_ibar_asserts (
    input logic                             clk_i,
    input logic                             reset_ni,
    input logic                             pilot_valid_i,
    input logic [pbch_pkg::PILOT_IDX_W-1:0] pilot_idx_i,
    input logic                             pilot_last_i,
    input logic                             corr_done_i,
    input logic                             ibar_valid_i
);
    import pbch_pkg::*;

    // pilots seen since the last subcarrier of the previous symbol
    logic [PILOT_IDX_W:0] pilot_cnt_q;
    int fail_count = 0;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            pilot_cnt_q <= '0;
        end else if (pilot_last_i) begin
            pilot_cnt_q <= '0;
        end else if (pilot_valid_i) begin
            pilot_cnt_q <= pilot_cnt_q + 1'b1;
        end
    end

    a_valid_pulse: assert property (@(posedge clk_i) disable iff (!reset_ni)
        ibar_valid_i |=> !ibar_valid_i)
        else begin
            fail_count++;
            $error("ibar_valid_o stayed high for two cycles");
        end

    // pilots of one symbol take the indices 0..63 in order
    a_idx_range: assert property (@(posedge clk_i) disable iff (!reset_ni)
        pilot_valid_i |-> (pilot_cnt_q < PILOTS_PER_SYM)
                          && (pilot_idx_i == pilot_cnt_q[PILOT_IDX_W-1:0]))
        else begin
            fail_count++;
            $error("pilot index out of range or out of order");
        end

    // corr_done is the registered copy of last
    a_done_after_last: assert property (@(posedge clk_i) disable iff (!reset_ni)
        corr_done_i == $past(pilot_last_i))
        else begin
            fail_count++;
            $error("corr_done does not follow pilot last by one cycle");
        end

endmodule

bind dmrs_correlator pbch_ibar_asserts u_corr_asserts (
    .clk_i(clk_i),
    .reset_ni(reset_ni),
    .pilot_valid_i(pilot.valid),
    .pilot_idx_i(pilot.idx),
    .pilot_last_i(pilot.last),
    .corr_done_i(corr_done_o),
    .ibar_valid_i(1'b0)
);

bind ibar_select pbch_ibar_asserts u_select_asserts (
    .clk_i(clk_i),
    .reset_ni(reset_ni),
    .pilot_valid_i(1'b0),
    .pilot_idx_i('0),
    .pilot_last_i(1'b0),
    .corr_done_i(1'b0),
    .ibar_valid_i(ibar_valid_o)
);

// ==== tests/tb_pbch_ibar_detector.sv ====
`timescale 1ns/1ps

module tb_pbch_ibar_detector;
    import pbch_pkg::*;

    typedef struct {
        int n_id;
        int ibar;
        int flips;
        bit gaps;
        bit ignored_start;
    } row_t;

    typedef struct {
        int ibar;
        int corr;
        int cyc;
    } result_t;

    localparam int NUM_ROWS = 12;
    localparam int SEQ_LEN = GOLD_SKIP + 2 * PILOTS_PER_SYM;
    // LOAD, SKIP and FILL together
    localparam int READY_CYCLES = 1 + GOLD_SKIP + 2 * PILOTS_PER_SYM;
    localparam logic [15:0] POS_AMP = 16'h5a82;
    localparam logic [15:0] NEG_AMP = 16'ha57e;

    logic clk_i;
    logic reset_ni;
    logic [NID_W-1:0] n_id_i;
    logic n_id_valid_i;
    logic pbch_start_i;
    logic [SAMPLE_W-1:0] sample_i;
    logic sample_valid_i;
    logic dmrs_ready_o;
    logic [IBAR_W-1:0] ibar_o;
    logic [CORR_W-1:0] ibar_corr_o;
    logic ibar_valid_o;

    row_t rows [NUM_ROWS];
    pilot_pair_t exp_tab [NUM_IBAR][PILOTS_PER_SYM];
    result_t exp_q [$];
    result_t mon_exp;
    logic [31:0] lfsr_q;
    int cyc = 0;
    int errors = 0;
    int results = 0;
    int assert_fails = 0;
    int cur_nid;
    bit abort = 1'b0;

    pbch_ibar_detector dut0 (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .n_id_i(n_id_i),
        .n_id_valid_i(n_id_valid_i),
        .pbch_start_i(pbch_start_i),
        .sample_i(sample_i),
        .sample_valid_i(sample_valid_i),
        .dmrs_ready_o(dmrs_ready_o),
        .ibar_o(ibar_o),
        .ibar_corr_o(ibar_corr_o),
        .ibar_valid_o(ibar_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cyc <= cyc + 1;

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic bit rand_bit();
        bit b;
        b = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) begin
            lfsr_q = lfsr_q ^ 32'h8020_0003;
        end
        return b;
    endfunction

    // reference Gold sequence c(n) for n = 0..127 after the 1600-bit skip
    function automatic logic [2*PILOTS_PER_SYM-1:0] gold_bits(input int n_id, input int ibar);
        bit x1 [SEQ_LEN];
        bit x2 [SEQ_LEN];
        int c_init;
        logic [2*PILOTS_PER_SYM-1:0] seq;
        c_init = 2048 * (ibar + 1) * (n_id / 4 + 1) + 64 * (ibar + 1) + n_id % 4;
        for (int n = 0; n < 31; n++) begin
            x1[n] = (n == 0);
            x2[n] = bit'((c_init >> n) & 1);
        end
        for (int n = 0; n + 31 < SEQ_LEN; n++) begin
            x1[n+31] = x1[n+3] ^ x1[n];
            x2[n+31] = x2[n+3] ^ x2[n+2] ^ x2[n+1] ^ x2[n];
        end
        for (int n = 0; n < 2 * PILOTS_PER_SYM; n++) begin
            seq[n] = x1[n+GOLD_SKIP] ^ x2[n+GOLD_SKIP];
        end
        return seq;
    endfunction

    task automatic load_nid(input int n_id, input bit ignored_start);
        logic [2*PILOTS_PER_SYM-1:0] seq;
        int accept_cyc;
        for (int c = 0; c < NUM_IBAR; c++) begin
            seq = gold_bits(n_id, c);
            for (int m = 0; m < PILOTS_PER_SYM; m++) begin
                exp_tab[c][m] = {seq[2*m], seq[2*m+1]};
            end
        end
        n_id_i = NID_W'(n_id);
        n_id_valid_i = 1'b1;
        @(negedge clk_i);
        n_id_valid_i = 1'b0;
        accept_cyc = cyc;
        if (dmrs_ready_o !== 1'b0) begin
            errors++;
            $display("FAILED dmrs_ready_o: got 0x%h expected 0x0", dmrs_ready_o);
        end
        if (ignored_start) begin
            // the table is being rebuilt, so this start and its samples must vanish
            pbch_start_i = 1'b1;
            @(negedge clk_i);
            pbch_start_i = 1'b0;
            sample_valid_i = 1'b1;
            repeat (300) @(negedge clk_i);
            sample_valid_i = 1'b0;
        end
        while (dmrs_ready_o !== 1'b1 && cyc - accept_cyc < READY_CYCLES + 100) begin
            @(negedge clk_i);
        end
        if (dmrs_ready_o !== 1'b1) begin
            errors++;
            abort = 1'b1;
            $display("timeout: dmrs_ready_o never rose after loading n_id %0d", n_id);
        end else if (cyc - accept_cyc != READY_CYCLES) begin
            errors++;
            $display("FAILED dmrs_ready_o latency: got 0x%h expected 0x%h",
                     cyc - accept_cyc, READY_CYCLES);
        end
    endtask

    task automatic send_symbol(input row_t row);
        pilot_pair_t rx [PILOTS_PER_SYM];
        result_t e;
        int bit_idx;
        int cnt;
        int last_cyc;
        bit re_neg;
        bit im_neg;
        for (int m = 0; m < PILOTS_PER_SYM; m++) begin
            rx[m] = exp_tab[row.ibar][m];
        end
        // 37 is odd, so the flipped positions never repeat
        for (int j = 0; j < row.flips; j++) begin
            bit_idx = (j * 37) % (2 * PILOTS_PER_SYM);
            rx[bit_idx/2][1 - bit_idx % 2] ^= 1'b1;
        end
        e.ibar = 0;
        e.corr = 0;
        for (int c = 0; c < NUM_IBAR; c++) begin
            cnt = 0;
            for (int m = 0; m < PILOTS_PER_SYM; m++) begin
                cnt = cnt + (rx[m][1] == exp_tab[c][m][1]) + (rx[m][0] == exp_tab[c][m][0]);
            end
            if (cnt > e.corr) begin
                e.corr = cnt;
                e.ibar = c;
            end
        end
        pbch_start_i = 1'b1;
        @(negedge clk_i);
        pbch_start_i = 1'b0;
        for (int k = 0; k < FFT_LEN; k++) begin
            if (row.gaps && rand_bit()) begin
                sample_valid_i = 1'b0;
                @(negedge clk_i);
            end
            if (k % 4 == row.n_id % 4) begin
                re_neg = rx[k/4][1];
                im_neg = rx[k/4][0];
            end else begin
                re_neg = rand_bit();
                im_neg = rand_bit();
            end
            sample_i = {im_neg ? NEG_AMP : POS_AMP, re_neg ? NEG_AMP : POS_AMP};
            sample_valid_i = 1'b1;
            last_cyc = cyc;
            @(negedge clk_i);
        end
        sample_valid_i = 1'b0;
        // input, pilot and counter registers, then the result register
        e.cyc = last_cyc + 4;
        exp_q.push_back(e);
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 400) begin
            @(negedge clk_i);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            abort = 1'b1;
            $display("timeout: %0d results still outstanding", exp_q.size());
        end
    endtask

    always @(negedge clk_i) begin
        if (reset_ni && ibar_valid_o) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("ibar_valid_o pulsed with no symbol outstanding at cycle %0d", cyc);
            end else begin
                mon_exp = exp_q.pop_front();
                results++;
                if (cyc != mon_exp.cyc) begin
                    errors++;
                    $display("FAILED ibar_valid_o cycle: got 0x%h expected 0x%h",
                             cyc, mon_exp.cyc);
                end
                if (ibar_o != IBAR_W'(mon_exp.ibar)) begin
                    errors++;
                    $display("FAILED ibar_o: got 0x%h expected 0x%h", ibar_o, mon_exp.ibar);
                end
                if (ibar_corr_o != CORR_W'(mon_exp.corr)) begin
                    errors++;
                    $display("FAILED ibar_corr_o: got 0x%h expected 0x%h",
                             ibar_corr_o, mon_exp.corr);
                end
            end
        end else if (exp_q.size() != 0 && cyc > exp_q[0].cyc) begin
            errors++;
            $display("no ibar_valid_o pulse for the symbol due at cycle %0d", exp_q[0].cyc);
            void'(exp_q.pop_front());
        end
    end

    initial begin
        // n_id, ibar, flipped bits, gaps, ignored start
        rows = '{'{0, 0, 0, 0, 1}, '{0, 5, 0, 0, 0}, '{0, 5, 3, 1, 0},
                 '{501, 1, 0, 0, 1}, '{501, 6, 0, 1, 0}, '{501, 2, 20, 0, 0},
                 '{1006, 3, 0, 0, 0}, '{1006, 7, 0, 1, 0}, '{1006, 4, 60, 0, 0},
                 '{347, 4, 0, 0, 0}, '{347, 2, 1, 1, 0}, '{347, 2, 0, 0, 0}};
        lfsr_q = 32'd74511;
        reset_ni = 1'b0;
        n_id_i = '0;
        n_id_valid_i = 1'b0;
        pbch_start_i = 1'b0;
        sample_i = '0;
        sample_valid_i = 1'b0;
        repeat (3) @(negedge clk_i);
        reset_ni = 1'b1;
        if ({dmrs_ready_o, ibar_valid_o, ibar_o, ibar_corr_o} !== '0) begin
            errors++;
            $display("FAILED outputs after reset: got 0x%h expected 0x0",
                     {dmrs_ready_o, ibar_valid_o, ibar_o, ibar_corr_o});
        end
        cur_nid = -1;
        for (int r = 0; r < NUM_ROWS && !abort; r++) begin
            if (rows[r].n_id != cur_nid) begin
                drain();
                if (!abort) begin
                    load_nid(rows[r].n_id, rows[r].ignored_start);
                end
                cur_nid = rows[r].n_id;
            end
            if (!abort) begin
                send_symbol(rows[r]);
            end
        end
        drain();
        assert_fails = dut0.u_corr.u_corr_asserts.fail_count
                       + dut0.u_select.u_select_asserts.fail_count;
        $display("%0d results checked, %0d errors, %0d assertion failures",
                 results, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
hw/pbch_pkg.sv
hw/pbch_ifs.sv
hw/pn_lfsr.sv
hw/pbch_dmrs_gen.sv
hw/pilot_demod.sv
hw/dmrs_correlator.sv
hw/ibar_select.sv
hw/pbch_ibar_detector.sv
tests/pbch_ibar_asserts.sv
tests/tb_pbch_ibar_detector.sv
